// File: verilog/pyr_geom_pkg.sv
package pyr_geom_pkg;

    localparam int IMG_W       = 16;   // level 0 and level 1
    localparam int IMG_H       = 16;
    localparam int HALF_W      = 8;    // level 2
    localparam int HALF_H      = 8;
    localparam int PIX_W       = 8;
    localparam int NPIX        = IMG_W * IMG_H;
    localparam int NPIX_HALF   = HALF_W * HALF_H;
    localparam int ADDR_W      = 8;
    localparam int HALF_ADDR_W = 6;
    localparam int RD_LAT      = 2;    // source memory and frame buffers alike

    typedef logic [PIX_W-1:0] pixel_t;
    typedef logic [$clog2(IMG_W)-1:0] coord_t;

    typedef struct packed {
        coord_t row;   // upper nibble
        coord_t col;
    } pix_rc_t;

    // one address word, seen as raster index or as row/column
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        pix_rc_t           rc;
    } pix_addr_t;

    typedef logic [HALF_ADDR_W-1:0] half_addr_t;

endpackage

// File: verilog/pyr_ctrl_pkg.sv
package pyr_ctrl_pkg;

    import pyr_geom_pkg::*;

    // sequencer stages, one per pyramid level produced
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        BLUR,
        DECIM
    } stage_t;

    // write strobe into a full-size level
    typedef struct packed {
        logic      valid;
        pix_addr_t addr;
        pixel_t    data;
    } pix_wr_t;

    // write strobe into the quarter-size level
    typedef struct packed {
        logic       valid;
        half_addr_t addr;
        pixel_t     data;
    } half_wr_t;

endpackage

// File: verilog/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer
    import pyr_geom_pkg::*;
    import pyr_ctrl_pkg::*;
(
    input  logic      clk_in,
    input  pix_wr_t   wr,
    input  logic      rd_en,
    input  pix_addr_t rd_addr,
    output pixel_t    rd_data
);

    pixel_t mem [NPIX];
    pixel_t rd_q;   // first read stage, like a block RAM latch

    always_ff @(posedge clk_in) begin
        if (wr.valid) begin
            mem[wr.addr.flat] <= wr.data;
        end
    end

    // two register stages give RD_LAT cycles from rd_en to data
    always_ff @(posedge clk_in) begin
        if (rd_en) begin
            rd_q <= mem[rd_addr.flat];
        end
        rd_data <= rd_q;   // output register
    end

    a_rd_addr_known: assert property (@(posedge clk_in)
        rd_en |-> !$isunknown(rd_addr));

endmodule

// File: verilog/image_loader.sv
`timescale 1ns/1ps

module image_loader
    import pyr_geom_pkg::*;
    import pyr_ctrl_pkg::*;
(
    input  logic      clk_in,
    input  logic      rst_in,
    input  logic      go,
    output logic      ext_rd_en,
    output pix_addr_t ext_rd_addr,
    input  pixel_t    ext_pixel,
    output pix_wr_t   wr,
    output logic      finished
);

    // read tag that follows the request until its pixel returns
    typedef struct packed {
        logic      valid;
        pix_addr_t addr;
    } rd_tag_t;

    logic      issuing;   // request phase
    logic      busy;      // go seen, last write not yet done
    pix_addr_t rd_ptr;
    rd_tag_t   tag_pipe [RD_LAT];
    logic      last_wr;

    assign ext_rd_en   = issuing;
    assign ext_rd_addr = rd_ptr;

    always_comb begin
        wr.valid = tag_pipe[RD_LAT-1].valid;
        wr.addr  = tag_pipe[RD_LAT-1].addr;
        wr.data  = ext_pixel;   // arrives together with its tag
    end

    assign last_wr = wr.valid && (wr.addr.flat == ADDR_W'(NPIX - 1));

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            issuing  <= 1'b0;
            busy     <= 1'b0;
            rd_ptr   <= '0;
            finished <= 1'b0;
            for (int i = 0; i < RD_LAT; i++) begin
                tag_pipe[i] <= '0;
            end
        end else begin
            finished <= last_wr;   // cycle after the final write
            if (go) begin
                issuing <= 1'b1;
                busy    <= 1'b1;
                rd_ptr  <= '0;
            end else if (issuing) begin
                rd_ptr.flat <= rd_ptr.flat + ADDR_W'(1);
                if (rd_ptr.flat == ADDR_W'(NPIX - 1)) begin
                    issuing <= 1'b0;
                end
            end
            if (last_wr) begin
                busy <= 1'b0;
            end
            tag_pipe[0] <= '{valid: issuing, addr: rd_ptr};
            for (int i = 1; i < RD_LAT; i++) begin
                tag_pipe[i] <= tag_pipe[i-1];
            end
        end
    end

    a_no_read_when_idle: assert property (@(posedge clk_in) disable iff (rst_in)
        ext_rd_en |-> busy);

endmodule

// File: verilog/gauss_blur.sv
`timescale 1ns/1ps

module gauss_blur
    import pyr_geom_pkg::*;
    import pyr_ctrl_pkg::*;
(
    input  logic      clk_in,
    input  logic      rst_in,
    input  logic      go,
    output logic      rd_en,
    output pix_addr_t rd_addr,
    input  pixel_t    rd_data,
    output pix_wr_t   wr,
    output logic      finished
);

    // per-tap info travelling alongside the buffer read
    typedef struct packed {
        logic      valid;
        logic      first;    // tap 0 restarts the sum
        logic      last;     // tap 8 completes it
        logic [2:0] weight;  // 1, 2 or 4
        pix_addr_t centre;
    } tap_t;

    logic       reading;
    pix_addr_t  ctr;         // centre pixel being filtered
    logic [1:0] kr;          // kernel row 0..2
    logic [1:0] kc;          // kernel column 0..2
    pix_addr_t  tap_addr;
    logic [2:0] tap_w;
    tap_t       tap_pipe [RD_LAT];
    tap_t       ret;
    logic [11:0] acc;        // max 16 * 255 fits
    logic       acc_done;
    pix_addr_t  acc_ctr;

    // step one neighbour towards k, holding at the image edge
    function automatic coord_t clamp_tap(input coord_t v, input logic [1:0] k,
                                         input coord_t lim);
        coord_t t;
        t = v;
        if (k == 2'd0 && v != '0) begin
            t = v - coord_t'(1);
        end
        if (k == 2'd2 && v != lim) begin
            t = v + coord_t'(1);
        end
        return t;
    endfunction

    always_comb begin
        tap_addr.rc.row = clamp_tap(ctr.rc.row, kr, coord_t'(IMG_H - 1));
        tap_addr.rc.col = clamp_tap(ctr.rc.col, kc, coord_t'(IMG_W - 1));
        tap_w = (kr == 2'd1 ? 3'd2 : 3'd1) * (kc == 2'd1 ? 3'd2 : 3'd1);
    end

    assign rd_en   = reading;
    assign rd_addr = tap_addr;
    assign ret     = tap_pipe[RD_LAT-1];   // lines up with rd_data

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            reading  <= 1'b0;
            ctr      <= '0;
            kr       <= '0;
            kc       <= '0;
            acc_done <= 1'b0;
            finished <= 1'b0;
            for (int i = 0; i < RD_LAT; i++) begin
                tap_pipe[i] <= '0;
            end
        end else begin
            if (go) begin
                reading <= 1'b1;
                ctr     <= '0;
                kr      <= '0;
                kc      <= '0;
            end else if (reading) begin
                kc <= (kc == 2'd2) ? 2'd0 : kc + 2'd1;
                if (kc == 2'd2) begin
                    kr <= (kr == 2'd2) ? 2'd0 : kr + 2'd1;
                    if (kr == 2'd2) begin   // all 9 taps issued for this centre
                        ctr.flat <= ctr.flat + ADDR_W'(1);
                        if (ctr.flat == ADDR_W'(NPIX - 1)) begin
                            reading <= 1'b0;
                        end
                    end
                end
            end
            tap_pipe[0] <= '{valid: reading,
                             first: reading && kr == 2'd0 && kc == 2'd0,
                             last: reading && kr == 2'd2 && kc == 2'd2,
                             weight: tap_w,
                             centre: ctr};
            for (int i = 1; i < RD_LAT; i++) begin
                tap_pipe[i] <= tap_pipe[i-1];
            end
            acc_done <= ret.valid && ret.last;
            finished <= acc_done && (acc_ctr.flat == ADDR_W'(NPIX - 1));
        end
    end

    always_ff @(posedge clk_in) begin
        if (ret.valid) begin
            acc     <= (ret.first ? 12'd0 : acc) + 12'(ret.weight) * 12'(rd_data);
            acc_ctr <= ret.centre;
        end
    end

    always_comb begin
        wr.valid = acc_done;
        wr.addr  = acc_ctr;
        wr.data  = acc[11:4];   // divide by 16, truncated
    end

    // the sum written must span 9 contiguous taps starting with a first tap
    a_write_after_accum: assert property (@(posedge clk_in) disable iff (rst_in)
        wr.valid |-> $past(ret.valid && ret.first, 9));

endmodule

// File: verilog/half_decimator.sv
`timescale 1ns/1ps

module half_decimator
    import pyr_geom_pkg::*;
    import pyr_ctrl_pkg::*;
(
    input  logic      clk_in,
    input  logic      rst_in,
    input  logic      go,
    output logic      rd_en,
    output pix_addr_t rd_addr,
    input  pixel_t    rd_data,
    output half_wr_t  wr,
    output logic      finished
);

    typedef struct packed {
        logic       valid;
        half_addr_t addr;
    } half_tag_t;

    logic                      reading;
    logic                      busy;
    logic [$clog2(HALF_H)-1:0] hr;   // level-2 row
    logic [$clog2(HALF_W)-1:0] hc;   // level-2 column
    half_tag_t                 tag_pipe [RD_LAT];
    logic                      last_wr;

    assign rd_en          = reading;
    assign rd_addr.rc.row = {hr, 1'b0};   // even rows of level 1
    assign rd_addr.rc.col = {hc, 1'b0};

    always_comb begin
        wr.valid = tag_pipe[RD_LAT-1].valid;
        wr.addr  = tag_pipe[RD_LAT-1].addr;
        wr.data  = rd_data;
    end

    assign last_wr = wr.valid && (wr.addr == half_addr_t'(NPIX_HALF - 1));

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            reading  <= 1'b0;
            busy     <= 1'b0;
            hr       <= '0;
            hc       <= '0;
            finished <= 1'b0;
            for (int i = 0; i < RD_LAT; i++) begin
                tag_pipe[i] <= '0;
            end
        end else begin
            finished <= last_wr;
            if (go) begin
                reading <= 1'b1;
                busy    <= 1'b1;
                hr      <= '0;
                hc      <= '0;
            end else if (reading) begin
                hc <= hc + 1'b1;   // wraps at HALF_W
                if (hc == ($bits(hc))'(HALF_W - 1)) begin
                    hr <= hr + 1'b1;
                    if (hr == ($bits(hr))'(HALF_H - 1)) begin
                        reading <= 1'b0;
                    end
                end
            end
            if (last_wr) begin
                busy <= 1'b0;
            end
            tag_pipe[0] <= '{valid: reading, addr: {hr, hc}};
            for (int i = 1; i < RD_LAT; i++) begin
                tag_pipe[i] <= tag_pipe[i-1];
            end
        end
    end

    a_no_write_when_idle: assert property (@(posedge clk_in) disable iff (rst_in)
        wr.valid |-> busy);

endmodule

// File: verilog/pyramid_top.sv
`timescale 1ns/1ps

module pyramid_top
    import pyr_geom_pkg::*;
    import pyr_ctrl_pkg::*;
(
    input  logic      clk_in,
    input  logic      rst_in,
    input  logic      start,
    output logic      ext_rd_en,
    output pix_addr_t ext_rd_addr,
    input  pixel_t    ext_pixel,
    output pix_wr_t   lvl0_wr,
    output pix_wr_t   lvl1_wr,
    output half_wr_t  lvl2_wr,
    output logic      done
);

    stage_t    stage;
    logic      load_go, blur_go, decim_go;
    logic      load_fin, blur_fin, decim_fin;
    logic      a_rd_en, b_rd_en;
    pix_addr_t a_rd_addr, b_rd_addr;
    pixel_t    a_rd_data, b_rd_data;

    // one go pulse on entering a stage, advance on that worker's finished
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            stage    <= IDLE;
            load_go  <= 1'b0;
            blur_go  <= 1'b0;
            decim_go <= 1'b0;
            done     <= 1'b0;
        end else begin
            load_go  <= 1'b0;
            blur_go  <= 1'b0;
            decim_go <= 1'b0;
            done     <= 1'b0;
            case (stage)
                IDLE: if (start) begin   // start elsewhere is ignored
                    stage   <= LOAD;
                    load_go <= 1'b1;
                end
                LOAD: if (load_fin) begin
                    stage   <= BLUR;
                    blur_go <= 1'b1;
                end
                BLUR: if (blur_fin) begin
                    stage    <= DECIM;
                    decim_go <= 1'b1;
                end
                DECIM: if (decim_fin) begin
                    stage <= IDLE;
                    done  <= 1'b1;
                end
                default: stage <= IDLE;
            endcase
        end
    end

    image_loader u_loader (.clk_in, .rst_in, .go(load_go), .ext_rd_en, .ext_rd_addr,
                           .ext_pixel, .wr(lvl0_wr), .finished(load_fin));

    frame_buffer u_buf_a (.clk_in, .wr(lvl0_wr), .rd_en(a_rd_en), .rd_addr(a_rd_addr),
                          .rd_data(a_rd_data));   // level 0

    gauss_blur u_blur (.clk_in, .rst_in, .go(blur_go), .rd_en(a_rd_en), .rd_addr(a_rd_addr),
                       .rd_data(a_rd_data), .wr(lvl1_wr), .finished(blur_fin));

    frame_buffer u_buf_b (.clk_in, .wr(lvl1_wr), .rd_en(b_rd_en), .rd_addr(b_rd_addr),
                          .rd_data(b_rd_data));   // level 1

    half_decimator u_decim (.clk_in, .rst_in, .go(decim_go), .rd_en(b_rd_en),
                            .rd_addr(b_rd_addr), .rd_data(b_rd_data), .wr(lvl2_wr),
                            .finished(decim_fin));

endmodule

// File: dv/pyramid_model.svh
`ifndef PYRAMID_MODEL_SVH
`define PYRAMID_MODEL_SVH

// binomial weight for a kernel offset of -1, 0 or +1
function automatic int tap_weight(input int off);
    return (off == 0) ? 2 : 1;
endfunction

// hold a coordinate inside the frame, so edge pixels repeat
function automatic int clamp_coord(input int v, input int lim);
    if (v < 0) return 0;
    if (v > lim) return lim;
    return v;
endfunction

// level-1 pixel at (r, c): 1-2-1 by 1-2-1 weighted sum, divided by 16 and truncated
function automatic pixel_t blur_at(input pixel_t img [NPIX], input int r, input int c);
    int sum;
    int rr;
    int cc;
    sum = 0;
    for (int dr = -1; dr <= 1; dr++) begin
        for (int dc = -1; dc <= 1; dc++) begin
            rr = clamp_coord(r + dr, IMG_H - 1);
            cc = clamp_coord(c + dc, IMG_W - 1);
            sum += tap_weight(dr) * tap_weight(dc) * int'(img[ADDR_W'(rr * IMG_W + cc)]);
        end
    end
    return pixel_t'(sum / 16);
endfunction

// level-2 pixel: level 1 taken at even row and even column
function automatic pixel_t decimate_at(input pixel_t lvl1 [NPIX], input int hr, input int hc);
    return lvl1[ADDR_W'(2 * hr * IMG_W + 2 * hc)];
endfunction

`endif

// File: dv/pyramid_tb.sv
`timescale 1ns/1ps

module pyramid_tb
    import pyr_geom_pkg::*;
    import pyr_ctrl_pkg::*;
();

    localparam int NUM_FRAMES  = 3;
    localparam int FRAME_LIMIT = 4000;   // cycles allowed from start to done
    localparam int SETTLE      = 20;     // quiet cycles watched after done
    localparam int WATCHDOG    = NUM_FRAMES * (FRAME_LIMIT + SETTLE + 8) + 50;

    logic      clk_in;
    logic      rst_in;
    logic      start;
    logic      ext_rd_en;
    pix_addr_t ext_rd_addr;
    pixel_t    ext_pixel;
    pix_wr_t   lvl0_wr;
    pix_wr_t   lvl1_wr;
    half_wr_t  lvl2_wr;
    logic      done;

    int        seed = 32'h3f2236c3;
    int        errors;
    int        n_tests;
    int        n_failed;
    int        n0;
    int        n1;
    int        n2;
    int        n_done;
    logic      frame_active;       // outputs must stay quiet while low
    pixel_t    src_img [NPIX];
    pixel_t    exp1 [NPIX];
    pixel_t    exp2 [NPIX_HALF];
    bit        seen0 [NPIX];
    bit        seen1 [NPIX];
    bit        seen2 [NPIX_HALF];
    logic      req_v [RD_LAT];     // reads in flight at the source memory
    pix_addr_t req_a [RD_LAT];

    `include "pyramid_model.svh"

    pyramid_top u_dut (.*);

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    // source memory answers each request RD_LAT cycles later
    initial begin
        ext_pixel = '0;
        forever begin
            @(posedge clk_in);
            #1;
            ext_pixel = req_v[RD_LAT-1] ? src_img[req_a[RD_LAT-1].flat] : 8'h00;
        end
    end

    task automatic check_level0();
        int a;
        a = int'(lvl0_wr.addr.flat);
        if (seen0[a]) begin
            $display("level 0 address %02h was written more than once", a);
            errors++;
        end
        seen0[a] = 1'b1;
        n0++;
        if (!req_v[RD_LAT-1] || req_a[RD_LAT-1] != lvl0_wr.addr) begin
            $display("level 0 write at %02h does not follow its read by two cycles", a);
            errors++;
        end
        if (lvl0_wr.data !== src_img[a]) begin
            $display("FAILED lvl0_wr.data at %02h: expected %02h, got %02h",
                     a, src_img[a], lvl0_wr.data);
            errors++;
        end
    endtask

    task automatic check_level1();
        int a;
        a = int'(lvl1_wr.addr.flat);
        if (seen1[a]) begin
            $display("level 1 address %02h was written more than once", a);
            errors++;
        end
        seen1[a] = 1'b1;
        n1++;
        if (lvl1_wr.data !== exp1[a]) begin
            $display("FAILED lvl1_wr.data at %02h: expected %02h, got %02h",
                     a, exp1[a], lvl1_wr.data);
            errors++;
        end
    endtask

    task automatic check_level2();
        int a;
        a = int'(lvl2_wr.addr);
        if (seen2[a]) begin
            $display("level 2 address %02h was written more than once", a);
            errors++;
        end
        seen2[a] = 1'b1;
        n2++;
        if (lvl2_wr.data !== exp2[a]) begin
            $display("FAILED lvl2_wr.data at %02h: expected %02h, got %02h",
                     a, exp2[a], lvl2_wr.data);
            errors++;
        end
    endtask

    // monitor samples outputs at the falling edge
    initial begin
        for (int i = 0; i < RD_LAT; i++) begin
            req_v[i] = 1'b0;
            req_a[i] = '0;
        end
        forever begin
            @(negedge clk_in);
            if (!frame_active && (ext_rd_en || lvl0_wr.valid || lvl1_wr.valid
                                  || lvl2_wr.valid || done)) begin
                $display("DUT output active while no frame runs, at %0t", $time);
                errors++;
            end
            if (lvl0_wr.valid) check_level0();
            if (lvl1_wr.valid) check_level1();
            if (lvl2_wr.valid) check_level2();
            if (done) begin
                n_done++;
                if (n2 != NPIX_HALF) begin
                    $display("done pulsed after only %0d level 2 writes", n2);
                    errors++;
                end
            end
            for (int i = RD_LAT - 1; i > 0; i--) begin
                req_v[i] = req_v[i-1];
                req_a[i] = req_a[i-1];
            end
            req_v[0] = ext_rd_en;
            req_a[0] = ext_rd_addr;
        end
    end

    task automatic pulse_start();
        @(posedge clk_in);
        #1;
        start = 1'b1;
        @(posedge clk_in);
        #1;
        start = 1'b0;
    endtask

    // fresh random frame plus the expected levels 1 and 2
    task automatic load_frame();
        for (int i = 0; i < NPIX; i++) begin
            src_img[i] = pixel_t'($random(seed));
            seen0[i]   = 1'b0;
            seen1[i]   = 1'b0;
        end
        for (int i = 0; i < NPIX; i++) begin
            exp1[i] = blur_at(src_img, i / IMG_W, i % IMG_W);
        end
        for (int i = 0; i < NPIX_HALF; i++) begin
            exp2[i]  = decimate_at(exp1, i / HALF_W, i % HALF_W);
            seen2[i] = 1'b0;
        end
        n0     = 0;
        n1     = 0;
        n2     = 0;
        n_done = 0;
    endtask

    task automatic check_count(input string what, input int got, input int want);
        if (got != want) begin
            $display("FAILED %s: expected %0h, got %0h", what, want, got);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        n_tests++;
        if (errors == errs_before) begin
            $display("test %s passed", name);
        end else begin
            n_failed++;
            $display("test %s failed with %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic run_frame(input int idx);
        int errs_before;
        int waited;
        errs_before = errors;
        load_frame();
        frame_active = 1'b1;
        pulse_start();
        waited = 0;
        while (n1 == 0 && waited < FRAME_LIMIT) begin   // blur under way
            @(posedge clk_in);
            waited++;
        end
        pulse_start();   // lands in BLUR and must be ignored
        while (n_done == 0 && waited < FRAME_LIMIT) begin
            @(posedge clk_in);
            waited++;
        end
        if (n_done == 0) begin
            $display("frame %0d: done did not arrive within %0d cycles", idx, FRAME_LIMIT);
            errors++;
        end
        frame_active = 1'b0;
        repeat (SETTLE) @(posedge clk_in);
        check_count("lvl0_wr write count", n0, NPIX);
        check_count("lvl1_wr write count", n1, NPIX);
        check_count("lvl2_wr write count", n2, NPIX_HALF);
        check_count("done pulse count", n_done, 1);
        report_test($sformatf("frame%0d", idx), errs_before);
    endtask

    initial begin
        rst_in       = 1'b1;
        start        = 1'b0;
        frame_active = 1'b0;
        errors       = 0;
        n_tests      = 0;
        n_failed     = 0;
        repeat (2) @(posedge clk_in);
        #1;
        rst_in = 1'b0;
        repeat (10) @(posedge clk_in);   // still idle so nothing may move
        report_test("reset_quiet", 0);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f);
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 n_tests, n_tests - n_failed, n_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk_in);
        $display("run did not finish within %0d cycles", WATCHDOG);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: src.f
+incdir+dv
verilog/pyr_geom_pkg.sv
verilog/pyr_ctrl_pkg.sv
verilog/frame_buffer.sv
verilog/image_loader.sv
verilog/gauss_blur.sv
verilog/half_decimator.sv
verilog/pyramid_top.sv
dv/pyramid_tb.sv

// File: run.sh
#!/bin/sh
# build and run the pyramid testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module pyramid_tb \
    -f src.f -Mdir obj_dir -o pyramid_sim
./obj_dir/pyramid_sim > sim.log
cat sim.log
if grep -qx '>>> PASS' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
